//--- verilog/dbg_uart_pkg.sv
// command and reply codes, debug register indices, bit timing, bus types and FSM states
`default_nettype none

package dbg_uart_pkg;

	// --------------------
	// vector types
	typedef logic [7:0]  byte_t;
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [3:0]  reg_adr_t;
	typedef logic [3:0]  sel_t;

	// --------------------
	// serial bit timing
	localparam int BIT_CYCLES = 16;
	localparam int BIT_CNT_W  = $clog2(BIT_CYCLES);

	typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

	// last clock of the first and second half of a bit
	localparam bit_cnt_t BIT_MID  = bit_cnt_t'(BIT_CYCLES / 2 - 1);
	localparam bit_cnt_t BIT_LAST = bit_cnt_t'(BIT_CYCLES - 1);

	// --------------------
	// host commands and replies
	localparam byte_t CMD_NOP       = 8'h00;
	localparam byte_t CMD_STATUS    = 8'h01;
	localparam byte_t CMD_DBG_WRITE = 8'h02;
	localparam byte_t CMD_DBG_READ  = 8'h03;
	localparam byte_t CMD_MEM_WRITE = 8'h04;
	localparam byte_t CMD_MEM_READ  = 8'h05;

	localparam byte_t ACK_NOP       = 8'h80;
	localparam byte_t ACK_STATUS    = 8'h81;
	localparam byte_t ACK_DBG_WRITE = 8'h82;
	localparam byte_t ACK_DBG_READ  = 8'h83;
	localparam byte_t ACK_MEM_WRITE = 8'h84;
	localparam byte_t ACK_MEM_READ  = 8'h85;

	// debug registers used for memory access
	localparam reg_adr_t DBG_REG_ADDR = 4'd2;
	localparam reg_adr_t DBG_REG_DBUS = 4'd6;

	// --------------------
	// command FSM states
	typedef enum logic [4:0] {
		ST_IDLE,
		ST_NOP_TX_ACK,
		ST_STAT_TX_ACK, ST_STAT_TX_DATA,
		ST_DW_RX_ADR, ST_DW_RX_DATA, ST_DW_BUS, ST_DW_TX_ACK,
		ST_DR_RX_ADR, ST_DR_BUS, ST_DR_TX_ACK, ST_DR_TX_DATA,
		ST_MW_RX_SIZE, ST_MW_RX_ADDR, ST_MW_RX_DATA, ST_MW_ADDR_BUS, ST_MW_DBUS, ST_MW_TX_ACK,
		ST_MR_RX_SIZE, ST_MR_RX_ADDR, ST_MR_TX_ACK, ST_MR_ADDR_BUS, ST_MR_DBUS, ST_MR_TX_DATA
	} cmd_state_e;

	// --------------------
	// debug bus
	typedef struct packed {
		reg_adr_t adr;
		word_t    dat;
		logic     we;
		sel_t     sel;
		logic     stb;
	} dbg_req_t;

	typedef struct packed {
		word_t dat;
		logic  ack;
	} dbg_rsp_t;

endpackage

`default_nettype wire

//--- verilog/dbg_uart_baud_timer.sv
// bit period counter with mid-bit and end-of-bit pulses
`timescale 1ns/1ps
`default_nettype none

module dbg_uart_baud_timer (
	input  logic clk,
	input  logic reset,
	input  logic restart_i,
	input  logic run_i,
	output logic mid_o,
	output logic end_o
);

	dbg_uart_pkg::bit_cnt_t cnt;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cnt <= '0;
		end else if (restart_i) begin
			cnt <= '0;
		end else if (run_i) begin
			// wraps so the pulses repeat every bit
			cnt <= (cnt == dbg_uart_pkg::BIT_LAST) ? '0 : cnt + 1'b1;
		end
	end

	// count is stale while a restart is pending
	assign mid_o = run_i & ~restart_i & (cnt == dbg_uart_pkg::BIT_MID);
	assign end_o = run_i & ~restart_i & (cnt == dbg_uart_pkg::BIT_LAST);

endmodule

`default_nettype wire

//--- verilog/dbg_uart_rx.sv
// serial receiver: start detect, mid-bit sampling, one byte per valid pulse
`timescale 1ns/1ps
`default_nettype none

module dbg_uart_rx (
	input  logic                clk,
	input  logic                reset,
	input  logic                uart_rx_i,
	input  logic                mid_i,
	output logic                restart_o,
	output logic                run_o,
	output logic                rx_valid_o,
	output dbg_uart_pkg::byte_t rx_data_o
);

	// [0] and [1] synchronize, [2] is the previous synced level
	logic [2:0]          rx_sync;
	logic                rx_bit;
	logic                busy;
	// 0 start, 1..8 data, 9 stop
	logic [3:0]          bit_idx;
	dbg_uart_pkg::byte_t shift;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_sync <= 3'b111;
		end else begin
			rx_sync <= {rx_sync[1:0], uart_rx_i};
		end
	end

	assign rx_bit    = rx_sync[1];
	assign restart_o = ~busy & rx_sync[2] & ~rx_sync[1];
	assign run_o     = busy;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy       <= 1'b0;
			bit_idx    <= '0;
			rx_valid_o <= 1'b0;
		end else begin
			rx_valid_o <= 1'b0;
			if (restart_o) begin
				busy    <= 1'b1;
				bit_idx <= '0;
			end else if (busy && mid_i) begin
				if (bit_idx == 4'd0 && rx_bit) begin
					// glitch, not a real start bit
					busy <= 1'b0;
				end else if (bit_idx == 4'd9) begin
					busy       <= 1'b0;
					rx_valid_o <= rx_bit;
				end else begin
					bit_idx <= bit_idx + 4'd1;
				end
			end
		end
	end

	// lsb first, so shift in from the top
	always_ff @(posedge clk) begin
		if (busy && mid_i && bit_idx != 4'd0 && bit_idx != 4'd9) begin
			shift <= {rx_bit, shift[7:1]};
		end
	end

	assign rx_data_o = shift;

endmodule

`default_nettype wire

//--- verilog/dbg_uart_tx.sv
// serial transmitter: valid/ready byte in, start, data and stop bits out
`timescale 1ns/1ps
`default_nettype none

module dbg_uart_tx (
	input  logic                clk,
	input  logic                reset,
	input  logic                tx_valid_i,
	input  dbg_uart_pkg::byte_t tx_data_i,
	output logic                tx_ready_o,
	input  logic                end_i,
	output logic                restart_o,
	output logic                run_o,
	output logic                uart_tx_o
);

	logic       busy;
	logic       accept;
	logic [3:0] bit_idx;
	// bit 0 is on the line
	logic [9:0] frame;

	assign tx_ready_o = ~busy;
	assign accept     = tx_valid_i & ~busy;
	assign restart_o  = accept;
	assign run_o      = busy;
	assign uart_tx_o  = frame[0];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy    <= 1'b0;
			bit_idx <= '0;
			frame   <= '1;
		end else if (accept) begin
			busy    <= 1'b1;
			bit_idx <= '0;
			frame   <= {1'b1, tx_data_i, 1'b0};
		end else if (busy && end_i) begin
			// ones fill in behind, line ends idle high
			frame <= {1'b1, frame[9:1]};
			if (bit_idx == 4'd9) begin
				busy <= 1'b0;
			end else begin
				bit_idx <= bit_idx + 4'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/dbg_cmd_fsm.sv
// command FSM: decodes host bytes, runs debug bus transfers, builds reply bytes
`timescale 1ns/1ps
`default_nettype none

module dbg_cmd_fsm (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   endian_i,
	input  logic                   rx_valid_i,
	input  dbg_uart_pkg::byte_t    rx_data_i,
	output logic                   tx_valid_o,
	output dbg_uart_pkg::byte_t    tx_data_o,
	input  logic                   tx_ready_i,
	output dbg_uart_pkg::dbg_req_t dbg_req_o,
	input  dbg_uart_pkg::dbg_rsp_t dbg_rsp_i
);

	dbg_uart_pkg::cmd_state_e state, state_n;
	dbg_uart_pkg::dbg_req_t   req, req_n;
	dbg_uart_pkg::byte_t      cnt, cnt_n;
	dbg_uart_pkg::byte_t      size, size_n;
	dbg_uart_pkg::byte_t      wr_byte, wr_byte_n;
	dbg_uart_pkg::addr_t      address, address_n, address_inc;
	dbg_uart_pkg::word_t      rdata, rdata_n;
	logic [1:0]               fld_lane;
	logic [1:0]               mem_lane;
	dbg_uart_pkg::sel_t       mem_sel;

	// DBG_ADDR write of the word that holds byte address a
	function automatic dbg_uart_pkg::dbg_req_t addr_write(input dbg_uart_pkg::addr_t a);
		dbg_uart_pkg::dbg_req_t r;
		r.adr = dbg_uart_pkg::DBG_REG_ADDR;
		r.dat = {a[31:2], 2'b00};
		r.we  = 1'b1;
		r.sel = 4'b1111;
		r.stb = 1'b1;
		return r;
	endfunction

	// byte k of a field sits in lane k, or 3-k for big endian
	assign fld_lane    = cnt[1:0] ^ {2{endian_i}};
	assign mem_lane    = address[1:0] ^ {2{endian_i}};
	assign mem_sel     = 4'b0001 << mem_lane;
	assign address_inc = address + 32'd1;
	assign dbg_req_o   = req;

	always_comb begin
		state_n    = state;
		req_n      = req;
		cnt_n      = cnt;
		size_n     = size;
		wr_byte_n  = wr_byte;
		address_n  = address;
		rdata_n    = rdata;
		tx_valid_o = 1'b0;
		tx_data_o  = '0;

		case (state)
		dbg_uart_pkg::ST_IDLE: begin
			if (rx_valid_i) begin
				cnt_n = '0;
				case (rx_data_i)
				dbg_uart_pkg::CMD_NOP:       state_n = dbg_uart_pkg::ST_NOP_TX_ACK;
				dbg_uart_pkg::CMD_STATUS:    state_n = dbg_uart_pkg::ST_STAT_TX_ACK;
				dbg_uart_pkg::CMD_DBG_WRITE: state_n = dbg_uart_pkg::ST_DW_RX_ADR;
				dbg_uart_pkg::CMD_DBG_READ:  state_n = dbg_uart_pkg::ST_DR_RX_ADR;
				dbg_uart_pkg::CMD_MEM_WRITE: state_n = dbg_uart_pkg::ST_MW_RX_SIZE;
				dbg_uart_pkg::CMD_MEM_READ:  state_n = dbg_uart_pkg::ST_MR_RX_SIZE;
				// unknown codes are dropped
				default:                     state_n = dbg_uart_pkg::ST_IDLE;
				endcase
			end
		end

		// --------------------
		// nop and status
		dbg_uart_pkg::ST_NOP_TX_ACK: begin
			tx_valid_o = 1'b1;
			tx_data_o  = dbg_uart_pkg::ACK_NOP;
			if (tx_ready_i) begin
				state_n = dbg_uart_pkg::ST_IDLE;
			end
		end
		dbg_uart_pkg::ST_STAT_TX_ACK: begin
			tx_valid_o = 1'b1;
			tx_data_o  = dbg_uart_pkg::ACK_STATUS;
			if (tx_ready_i) begin
				state_n = dbg_uart_pkg::ST_STAT_TX_DATA;
			end
		end
		dbg_uart_pkg::ST_STAT_TX_DATA: begin
			tx_valid_o = 1'b1;
			tx_data_o  = {7'd0, endian_i};
			if (tx_ready_i) begin
				state_n = dbg_uart_pkg::ST_IDLE;
			end
		end

		// --------------------
		// debug register write and read
		dbg_uart_pkg::ST_DW_RX_ADR, dbg_uart_pkg::ST_DR_RX_ADR: begin
			if (rx_valid_i) begin
				req_n.adr = rx_data_i[3:0];
				req_n.sel = rx_data_i[7:4];
				req_n.we  = (state == dbg_uart_pkg::ST_DW_RX_ADR);
				if (state == dbg_uart_pkg::ST_DW_RX_ADR) begin
					state_n = dbg_uart_pkg::ST_DW_RX_DATA;
				end else begin
					// a read has no more request bytes
					req_n.stb = 1'b1;
					state_n   = dbg_uart_pkg::ST_DR_BUS;
				end
			end
		end
		dbg_uart_pkg::ST_DW_RX_DATA: begin
			if (rx_valid_i) begin
				req_n.dat[{fld_lane, 3'b000} +: 8] = rx_data_i;
				cnt_n = cnt + 8'd1;
				if (cnt[1:0] == 2'd3) begin
					req_n.stb = 1'b1;
					state_n   = dbg_uart_pkg::ST_DW_BUS;
				end
			end
		end
		dbg_uart_pkg::ST_DW_BUS: begin
			if (dbg_rsp_i.ack) begin
				req_n.stb = 1'b0;
				state_n   = dbg_uart_pkg::ST_DW_TX_ACK;
			end
		end
		dbg_uart_pkg::ST_DW_TX_ACK: begin
			tx_valid_o = 1'b1;
			tx_data_o  = dbg_uart_pkg::ACK_DBG_WRITE;
			if (tx_ready_i) begin
				state_n = dbg_uart_pkg::ST_IDLE;
			end
		end
		dbg_uart_pkg::ST_DR_BUS: begin
			if (dbg_rsp_i.ack) begin
				req_n.stb = 1'b0;
				rdata_n   = dbg_rsp_i.dat;
				state_n   = dbg_uart_pkg::ST_DR_TX_ACK;
			end
		end
		dbg_uart_pkg::ST_DR_TX_ACK: begin
			tx_valid_o = 1'b1;
			tx_data_o  = dbg_uart_pkg::ACK_DBG_READ;
			if (tx_ready_i) begin
				state_n = dbg_uart_pkg::ST_DR_TX_DATA;
			end
		end
		dbg_uart_pkg::ST_DR_TX_DATA: begin
			tx_valid_o = 1'b1;
			tx_data_o  = rdata[{fld_lane, 3'b000} +: 8];
			if (tx_ready_i) begin
				cnt_n = cnt + 8'd1;
				if (cnt[1:0] == 2'd3) begin
					state_n = dbg_uart_pkg::ST_IDLE;
				end
			end
		end

		// --------------------
		// memory header, shared by write and read
		dbg_uart_pkg::ST_MW_RX_SIZE, dbg_uart_pkg::ST_MR_RX_SIZE: begin
			if (rx_valid_i) begin
				size_n  = rx_data_i;
				state_n = (state == dbg_uart_pkg::ST_MW_RX_SIZE) ?
					dbg_uart_pkg::ST_MW_RX_ADDR : dbg_uart_pkg::ST_MR_RX_ADDR;
			end
		end
		dbg_uart_pkg::ST_MW_RX_ADDR, dbg_uart_pkg::ST_MR_RX_ADDR: begin
			if (rx_valid_i) begin
				address_n[{fld_lane, 3'b000} +: 8] = rx_data_i;
				cnt_n = cnt + 8'd1;
				if (cnt[1:0] == 2'd3) begin
					// from here cnt counts data bytes
					cnt_n   = '0;
					state_n = (state == dbg_uart_pkg::ST_MW_RX_ADDR) ?
						dbg_uart_pkg::ST_MW_RX_DATA : dbg_uart_pkg::ST_MR_TX_ACK;
				end
			end
		end

		// --------------------
		// memory write, one byte per DBG_ADDR + DBG_DBUS pair
		dbg_uart_pkg::ST_MW_RX_DATA: begin
			if (rx_valid_i) begin
				wr_byte_n = rx_data_i;
				req_n     = addr_write(address);
				state_n   = dbg_uart_pkg::ST_MW_ADDR_BUS;
			end
		end
		dbg_uart_pkg::ST_MW_ADDR_BUS, dbg_uart_pkg::ST_MR_ADDR_BUS: begin
			if (dbg_rsp_i.ack) begin
				req_n.stb = 1'b0;
				req_n.adr = dbg_uart_pkg::DBG_REG_DBUS;
				req_n.sel = mem_sel;
				req_n.we  = (state == dbg_uart_pkg::ST_MW_ADDR_BUS);
				req_n.dat = {4{wr_byte}};
				state_n   = (state == dbg_uart_pkg::ST_MW_ADDR_BUS) ?
					dbg_uart_pkg::ST_MW_DBUS : dbg_uart_pkg::ST_MR_DBUS;
			end
		end
		dbg_uart_pkg::ST_MW_DBUS: begin
			// strobe is low for one cycle after the address ack
			if (!req.stb) begin
				req_n.stb = 1'b1;
			end else if (dbg_rsp_i.ack) begin
				req_n.stb = 1'b0;
				cnt_n     = cnt + 8'd1;
				address_n = address_inc;
				state_n   = (cnt == size) ?
					dbg_uart_pkg::ST_MW_TX_ACK : dbg_uart_pkg::ST_MW_RX_DATA;
			end
		end
		dbg_uart_pkg::ST_MW_TX_ACK: begin
			tx_valid_o = 1'b1;
			tx_data_o  = dbg_uart_pkg::ACK_MEM_WRITE;
			if (tx_ready_i) begin
				state_n = dbg_uart_pkg::ST_IDLE;
			end
		end

		// --------------------
		// memory read
		dbg_uart_pkg::ST_MR_TX_ACK: begin
			tx_valid_o = 1'b1;
			tx_data_o  = dbg_uart_pkg::ACK_MEM_READ;
			if (tx_ready_i) begin
				req_n   = addr_write(address);
				state_n = dbg_uart_pkg::ST_MR_ADDR_BUS;
			end
		end
		dbg_uart_pkg::ST_MR_DBUS: begin
			if (!req.stb) begin
				req_n.stb = 1'b1;
			end else if (dbg_rsp_i.ack) begin
				req_n.stb = 1'b0;
				rdata_n   = dbg_rsp_i.dat;
				state_n   = dbg_uart_pkg::ST_MR_TX_DATA;
			end
		end
		dbg_uart_pkg::ST_MR_TX_DATA: begin
			tx_valid_o = 1'b1;
			tx_data_o  = rdata[{mem_lane, 3'b000} +: 8];
			if (tx_ready_i) begin
				cnt_n     = cnt + 8'd1;
				address_n = address_inc;
				if (cnt == size) begin
					state_n = dbg_uart_pkg::ST_IDLE;
				end else begin
					req_n   = addr_write(address_inc);
					state_n = dbg_uart_pkg::ST_MR_ADDR_BUS;
				end
			end
		end

		default: state_n = dbg_uart_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= dbg_uart_pkg::ST_IDLE;
			req   <= '0;
			cnt   <= '0;
		end else begin
			state <= state_n;
			req   <= req_n;
			cnt   <= cnt_n;
		end
	end

	always_ff @(posedge clk) begin
		size    <= size_n;
		wr_byte <= wr_byte_n;
		address <= address_n;
		rdata   <= rdata_n;
	end

endmodule

`default_nettype wire

//--- verilog/dbg_uart_top.sv
// debug port top: receiver, transmitter, their bit timers and the command FSM
`timescale 1ns/1ps
`default_nettype none

module dbg_uart_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   endian_i,
	input  logic                   uart_rx_i,
	output logic                   uart_tx_o,
	output dbg_uart_pkg::dbg_req_t dbg_req_o,
	input  dbg_uart_pkg::dbg_rsp_t dbg_rsp_i
);

	logic                rx_restart;
	logic                rx_run;
	logic                rx_mid;
	logic                rx_valid;
	dbg_uart_pkg::byte_t rx_data;

	logic                tx_restart;
	logic                tx_run;
	logic                tx_end;
	logic                tx_valid;
	logic                tx_ready;
	dbg_uart_pkg::byte_t tx_data;

	// --------------------
	// receive side samples at mid-bit
	dbg_uart_baud_timer u_rx_timer (
		.clk       (clk),
		.reset     (reset),
		.restart_i (rx_restart),
		.run_i     (rx_run),
		.mid_o     (rx_mid),
		.end_o     ()
	);

	dbg_uart_rx u_rx (
		.clk        (clk),
		.reset      (reset),
		.uart_rx_i  (uart_rx_i),
		.mid_i      (rx_mid),
		.restart_o  (rx_restart),
		.run_o      (rx_run),
		.rx_valid_o (rx_valid),
		.rx_data_o  (rx_data)
	);

	// --------------------
	// transmit side shifts at end of bit
	dbg_uart_baud_timer u_tx_timer (
		.clk       (clk),
		.reset     (reset),
		.restart_i (tx_restart),
		.run_i     (tx_run),
		.mid_o     (),
		.end_o     (tx_end)
	);

	dbg_uart_tx u_tx (
		.clk        (clk),
		.reset      (reset),
		.tx_valid_i (tx_valid),
		.tx_data_i  (tx_data),
		.tx_ready_o (tx_ready),
		.end_i      (tx_end),
		.restart_o  (tx_restart),
		.run_o      (tx_run),
		.uart_tx_o  (uart_tx_o)
	);

	dbg_cmd_fsm u_fsm (
		.clk        (clk),
		.reset      (reset),
		.endian_i   (endian_i),
		.rx_valid_i (rx_valid),
		.rx_data_i  (rx_data),
		.tx_valid_o (tx_valid),
		.tx_data_o  (tx_data),
		.tx_ready_i (tx_ready),
		.dbg_req_o  (dbg_req_o),
		.dbg_rsp_i  (dbg_rsp_i)
	);

endmodule

`default_nettype wire

//--- testbench/dbg_uart_checker.sv
// checker: reference model of the debug target, serial reply decoder and bus transfer monitor
`timescale 1ns/1ps
`default_nettype none

module dbg_uart_checker (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   uart_tx_i,
	input  dbg_uart_pkg::dbg_req_t dbg_req_i,
	input  dbg_uart_pkg::dbg_rsp_t dbg_rsp_i,
	output int                     pending_o,
	output logic                   line_busy_o,
	output int                     errors_o
);

	dbg_uart_pkg::byte_t    reply_q[$];
	dbg_uart_pkg::dbg_req_t bus_q[$];
	dbg_uart_pkg::word_t    regs[16];
	dbg_uart_pkg::byte_t    mem[256];
	int                     ser_errors;
	int                     bus_errors;

	assign errors_o = ser_errors + bus_errors;

	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = dbg_uart_pkg::byte_t'(i) ^ 8'ha5;
		end
		for (int i = 0; i < 16; i++) begin
			regs[i] = (dbg_uart_pkg::word_t'(i) * 32'h11111111) ^ 32'ha5a5a5a5;
		end
		ser_errors  = 0;
		bus_errors  = 0;
		pending_o   = 0;
		line_busy_o = 1'b0;
	end

	function automatic dbg_uart_pkg::dbg_req_t make_req(input dbg_uart_pkg::reg_adr_t adr,
			input dbg_uart_pkg::word_t dat, input logic we, input dbg_uart_pkg::sel_t sel);
		dbg_uart_pkg::dbg_req_t r;
		r.adr = adr;
		r.dat = dat;
		r.we  = we;
		r.sel = sel;
		r.stb = 1'b1;
		return r;
	endfunction

	// queues the bus transfers and reply bytes that one host command must cause
	function automatic void expect_command(input dbg_uart_pkg::byte_t code,
			input dbg_uart_pkg::byte_t sa, input dbg_uart_pkg::word_t data,
			input dbg_uart_pkg::byte_t size, input dbg_uart_pkg::addr_t addr,
			input logic [63:0] wbytes, input logic e);
		dbg_uart_pkg::word_t w;
		dbg_uart_pkg::addr_t a;
		dbg_uart_pkg::byte_t b;
		logic [1:0]          lane;
		case (code)
		dbg_uart_pkg::CMD_NOP: reply_q.push_back(dbg_uart_pkg::ACK_NOP);
		dbg_uart_pkg::CMD_STATUS: begin
			reply_q.push_back(dbg_uart_pkg::ACK_STATUS);
			reply_q.push_back({7'd0, e});
		end
		dbg_uart_pkg::CMD_DBG_WRITE: begin
			w = '0;
			for (int k = 0; k < 4; k++) begin
				lane = 2'(k) ^ {2{e}};
				w[8*lane +: 8] = data[8*k +: 8];
			end
			bus_q.push_back(make_req(sa[3:0], w, 1'b1, sa[7:4]));
			for (int l = 0; l < 4; l++) begin
				if (sa[4+l]) begin
					regs[sa[3:0]][8*l +: 8] = w[8*l +: 8];
				end
			end
			reply_q.push_back(dbg_uart_pkg::ACK_DBG_WRITE);
		end
		dbg_uart_pkg::CMD_DBG_READ: begin
			bus_q.push_back(make_req(sa[3:0], '0, 1'b0, sa[7:4]));
			reply_q.push_back(dbg_uart_pkg::ACK_DBG_READ);
			for (int k = 0; k < 4; k++) begin
				lane = 2'(k) ^ {2{e}};
				reply_q.push_back(regs[sa[3:0]][8*lane +: 8]);
			end
		end
		dbg_uart_pkg::CMD_MEM_WRITE, dbg_uart_pkg::CMD_MEM_READ: begin
			if (code == dbg_uart_pkg::CMD_MEM_READ) begin
				reply_q.push_back(dbg_uart_pkg::ACK_MEM_READ);
			end
			for (int i = 0; i <= int'(size); i++) begin
				a    = addr + dbg_uart_pkg::addr_t'(i);
				lane = a[1:0] ^ {2{e}};
				b    = wbytes[8*i +: 8];
				bus_q.push_back(make_req(dbg_uart_pkg::DBG_REG_ADDR, {a[31:2], 2'b00},
					1'b1, 4'b1111));
				if (code == dbg_uart_pkg::CMD_MEM_WRITE) begin
					bus_q.push_back(make_req(dbg_uart_pkg::DBG_REG_DBUS, {4{b}}, 1'b1,
						4'b0001 << lane));
					mem[a[7:0]] = b;
				end else begin
					bus_q.push_back(make_req(dbg_uart_pkg::DBG_REG_DBUS, '0, 1'b0,
						4'b0001 << lane));
					reply_q.push_back(mem[a[7:0]]);
				end
			end
			if (code == dbg_uart_pkg::CMD_MEM_WRITE) begin
				reply_q.push_back(dbg_uart_pkg::ACK_MEM_WRITE);
			end
		end
		default: ;
		endcase
	endfunction

	function automatic int mismatch(input string name, input logic [31:0] exp_v,
			input logic [31:0] got_v);
		if (exp_v !== got_v) begin
			$display("ERROR %0t: %s expected %h actual %h", $time, name, exp_v, got_v);
			return 1;
		end
		return 0;
	endfunction

	// --------------------
	// bus monitor, sampled on the falling edge
	initial begin
		dbg_uart_pkg::dbg_req_t exp_req;
		forever begin
			@(negedge clk);
			pending_o = reply_q.size() + bus_q.size();
			if (reset) begin
				bus_errors += mismatch("uart_tx_o", 32'd1, {31'd0, uart_tx_i});
				bus_errors += mismatch("dbg_req_o.stb", 32'd0, {31'd0, dbg_req_i.stb});
			end else if (dbg_req_i.stb && dbg_rsp_i.ack) begin
				if (bus_q.size() == 0) begin
					$display("ERROR %0t: bus transfer to register %0d that no command asked for",
						$time, dbg_req_i.adr);
					bus_errors++;
				end else begin
					exp_req = bus_q.pop_front();
					bus_errors += mismatch("dbg_req_o.adr", 32'(exp_req.adr), 32'(dbg_req_i.adr));
					bus_errors += mismatch("dbg_req_o.we", 32'(exp_req.we), 32'(dbg_req_i.we));
					bus_errors += mismatch("dbg_req_o.sel", 32'(exp_req.sel), 32'(dbg_req_i.sel));
					if (exp_req.we) begin
						bus_errors += mismatch("dbg_req_o.dat", exp_req.dat, dbg_req_i.dat);
					end
				end
			end
		end
	end

	// --------------------
	// serial reply decoder, one byte per frame
	initial begin
		dbg_uart_pkg::byte_t b;
		forever begin
			@(negedge clk);
			if (!reset && !uart_tx_i) begin
				line_busy_o = 1'b1;
				// to the middle of the start bit
				repeat (dbg_uart_pkg::BIT_CYCLES / 2 - 1) @(negedge clk);
				for (int i = 0; i < 8; i++) begin
					repeat (dbg_uart_pkg::BIT_CYCLES) @(negedge clk);
					b[i] = uart_tx_i;
				end
				repeat (dbg_uart_pkg::BIT_CYCLES) @(negedge clk);
				ser_errors += mismatch("uart_tx_o stop bit", 32'd1, {31'd0, uart_tx_i});
				if (reply_q.size() == 0) begin
					$display("ERROR %0t: reply byte %h arrived with no reply expected", $time, b);
					ser_errors++;
				end else begin
					ser_errors += mismatch("uart_tx_o byte", 32'(reply_q.pop_front()), 32'(b));
				end
				line_busy_o = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_dbg_uart.sv
// testbench top with clock, reset, serial host with random commands and debug target model
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_uart;

	localparam int NUM_CMDS = 60;
	localparam int TIMEOUT  = 40 * dbg_uart_pkg::BIT_CYCLES;

	logic                   clk;
	logic                   reset;
	logic                   endian;
	logic                   host_tx;
	logic                   uart_tx;
	dbg_uart_pkg::dbg_req_t req;
	dbg_uart_pkg::dbg_rsp_t rsp;
	int                     pending;
	logic                   line_busy;
	int                     errors;

	integer                 seed;
	logic                   timed_out;
	dbg_uart_pkg::word_t    regs[16];
	dbg_uart_pkg::byte_t    mem[256];

	dbg_uart_top uut (
		.clk       (clk),
		.reset     (reset),
		.endian_i  (endian),
		.uart_rx_i (host_tx),
		.uart_tx_o (uart_tx),
		.dbg_req_o (req),
		.dbg_rsp_i (rsp)
	);

	dbg_uart_checker chk (
		.clk         (clk),
		.reset       (reset),
		.uart_tx_i   (uart_tx),
		.dbg_req_i   (req),
		.dbg_rsp_i   (rsp),
		.pending_o   (pending),
		.line_busy_o (line_busy),
		.errors_o    (errors)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// --------------------
	// debug target acks after 0 to 3 cycles
	initial begin
		int                  delay;
		dbg_uart_pkg::byte_t idx;
		logic [1:0]          lane;
		for (int i = 0; i < 256; i++) begin
			mem[i] = dbg_uart_pkg::byte_t'(i) ^ 8'ha5;
		end
		for (int i = 0; i < 16; i++) begin
			regs[i] = (dbg_uart_pkg::word_t'(i) * 32'h11111111) ^ 32'ha5a5a5a5;
		end
		rsp = '0;
		forever begin
			@(posedge clk);
			#2;
			if (req.stb) begin
				delay = {$random(seed)} % 4;
				repeat (delay) begin
					@(posedge clk);
					#2;
				end
				rsp.ack = 1'b1;
				rsp.dat = regs[req.adr];
				for (int l = 0; l < 4; l++) begin
					lane = 2'(l) ^ {2{endian}};
					idx  = {regs[dbg_uart_pkg::DBG_REG_ADDR][7:2], 2'b00} + {6'd0, lane};
					if (req.adr == dbg_uart_pkg::DBG_REG_DBUS) begin
						rsp.dat[8*l +: 8] = mem[idx];
						if (req.we && req.sel[l]) begin
							mem[idx] = req.dat[8*l +: 8];
						end
					end else if (req.we && req.sel[l]) begin
						regs[req.adr][8*l +: 8] = req.dat[8*l +: 8];
					end
				end
				@(posedge clk);
				#2;
				rsp.ack = 1'b0;
			end
		end
	end

	// one serial frame sent lsb first
	task automatic send_byte(input dbg_uart_pkg::byte_t b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			host_tx = frame[i];
			repeat (dbg_uart_pkg::BIT_CYCLES) @(posedge clk);
			#2;
		end
	endtask

	// waits until every expected byte and transfer is seen and the reply line is idle
	task automatic wait_for_replies();
		int idle;
		int last;
		idle = 0;
		last = -1;
		while (!timed_out && (pending != 0 || line_busy)) begin
			@(posedge clk);
			#2;
			if (pending != last) begin
				last = pending;
				idle = 0;
			end else begin
				idle = idle + 1;
				if (idle > TIMEOUT) begin
					$display("timeout: the DUT stopped answering with %0d items outstanding",
						pending);
					timed_out = 1'b1;
				end
			end
		end
	endtask

	task automatic run_command(input int kind);
		dbg_uart_pkg::byte_t code;
		dbg_uart_pkg::byte_t sa;
		dbg_uart_pkg::word_t data;
		dbg_uart_pkg::byte_t size;
		dbg_uart_pkg::addr_t addr;
		logic [63:0]         wbytes;
		code   = (kind < 6) ? dbg_uart_pkg::byte_t'(kind) : 8'h06 + 8'({$random(seed)} % 120);
		sa     = dbg_uart_pkg::byte_t'($random(seed));
		// registers 2 and 6 belong to memory access
		if (sa[3:0] == dbg_uart_pkg::DBG_REG_ADDR || sa[3:0] == dbg_uart_pkg::DBG_REG_DBUS) begin
			sa[0] = 1'b1;
		end
		data   = $random(seed);
		size   = dbg_uart_pkg::byte_t'({$random(seed)} % 8);
		addr   = dbg_uart_pkg::addr_t'({$random(seed)} % 256);
		wbytes = {$random(seed), $random(seed)};
		chk.expect_command(code, sa, data, size, addr, wbytes, endian);
		send_byte(code);
		case (code)
		dbg_uart_pkg::CMD_DBG_WRITE, dbg_uart_pkg::CMD_DBG_READ: begin
			send_byte(sa);
			if (code == dbg_uart_pkg::CMD_DBG_WRITE) begin
				for (int k = 0; k < 4; k++) begin
					send_byte(data[8*k +: 8]);
				end
			end
		end
		dbg_uart_pkg::CMD_MEM_WRITE, dbg_uart_pkg::CMD_MEM_READ: begin
			send_byte(size);
			for (int k = 0; k < 4; k++) begin
				send_byte(addr[8*((endian ? 3 : 0) ^ k) +: 8]);
			end
			for (int i = 0; i <= int'(size) && code == dbg_uart_pkg::CMD_MEM_WRITE; i++) begin
				send_byte(wbytes[8*i +: 8]);
			end
		end
		default: ;
		endcase
		if (kind >= 6) begin
			// only silence is expected here
			repeat (TIMEOUT) @(posedge clk);
			#2;
		end
		wait_for_replies();
	endtask

	initial begin
		seed      = 32'h734f;
		reset     = 1'b1;
		endian    = 1'b0;
		host_tx   = 1'b1;
		timed_out = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		for (int n = 0; n < NUM_CMDS && !timed_out; n++) begin
			endian = 1'($random(seed));
			run_command((n < 2) ? n : {$random(seed)} % 7);
		end
		$display("checks done: %0d errors, timeout %0d", errors, timed_out);
		if (timed_out || errors != 0) begin
			$display("TEST FAILED");
		end else begin
			$display("TEST PASSED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
verilog/dbg_uart_pkg.sv
verilog/dbg_uart_baud_timer.sv
verilog/dbg_uart_rx.sv
verilog/dbg_uart_tx.sv
verilog/dbg_cmd_fsm.sv
verilog/dbg_uart_top.sv
testbench/dbg_uart_checker.sv
testbench/tb_dbg_uart.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_dbg_uart
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= run.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
